// File: flist.f
verilog/servo_sig_pkg.sv
verilog/servo_cfg_pkg.sv
verilog/iir_first_order.sv
verilog/adc_filter_bank.sv
verilog/sample_buffer.sv
verilog/dac_output_stage.sv
verilog/servo_top.sv
sim/tb_servo_top.sv

// File: Makefile
# Verilator build and run for the servo signal path testbench

VERILATOR ?= verilator
TOP       ?= tb_servo_top
FLIST     ?= flist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing
PASS_MSG  ?= all tests passed
FAIL_MSG  ?= tests failed

SOURCES := $(shell grep -v '^+' $(FLIST))
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: $(SIM_BIN)

# rebuilt only when a source or the file list changes
$(SIM_BIN): $(SOURCES) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FLIST)

run: $(SIM_BIN)
	$(SIM_BIN) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "simulation reported failure"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "simulation ended without a result"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: sim/tb_servo_top.sv
////////////////////////////////////////////////////////////////////////////
// testbench for servo_top: reference model of filters, difference, dac word
////////////////////////////////////////////////////////////////////////////

`default_nettype none

module tb_servo_top
	import servo_sig_pkg::*;
	import servo_cfg_pkg::*;
();

	localparam int BUF_DEPTH     = 8;
	localparam int unsigned SEED = 53272;
	localparam int N_BYPASS      = 200;
	localparam int N_FILTER      = 300;
	localparam int N_RANDOM      = 1000;
	localparam int TOTAL_SAMPLES = 4 + N_BYPASS + 2 * N_FILTER + BUF_DEPTH + 1 + N_RANDOM;
	// worst handshake mix, cycles per sample
	localparam int CYCLE_ALLOW   = 16;
	localparam int STALL_LIMIT   = 200;
	localparam int DRAIN_LIMIT   = 1000;
	localparam int READY_HIGH    = 0;
	localparam int READY_LOW     = 1;
	localparam int READY_RANDOM  = 2;
	// saturation rails of the filter output
	localparam longint SIG_MAX = (longint'(1) <<< (SIGNAL_WIDTH - 1)) - 1;
	localparam longint SIG_MIN = -(longint'(1) <<< (SIGNAL_WIDTH - 1));

	logic        clk1;
	logic        i_rst;
	adc_pair_t   i_adc;
	logic        i_adc_valid;
	logic        o_adc_ready;
	filter_cfg_t i_filter_cfg;
	dac_word_t   o_dac;
	logic        o_dac_valid;
	logic        i_dac_ready;

	dac_word_t   exp_q [$];
	longint      model_xp [2];
	longint      model_yp [2];
	string       cur_test;
	int          ready_mode;
	int unsigned err_count;
	int unsigned check_count;
	int unsigned test_count;
	int unsigned fail_tests;
	int unsigned test_err_start;
	int unsigned bp_accepted;

	servo_top #(
		.BUF_DEPTH    (BUF_DEPTH),
		.CREDIT_WIDTH (4)
	) u_dut (
		.i_clk1       (clk1),
		.i_rst        (i_rst),
		.i_adc        (i_adc),
		.i_adc_valid  (i_adc_valid),
		.o_adc_ready  (o_adc_ready),
		.i_filter_cfg (i_filter_cfg),
		.o_dac        (o_dac),
		.o_dac_valid  (o_dac_valid),
		.i_dac_ready  (i_dac_ready)
	);

	initial begin
		clk1 = 1'b0;
		forever #20 clk1 = ~clk1;
	end

	////////////////////////////////////////////////////////////////////////////
	// reference model

	// one section: shift by frac bits, clip to the signal rails
	function automatic longint iir_ref(iir_cfg_t cfg, longint x, longint xp, longint yp);
		longint acc;
		if (!cfg.on) begin
			return x;
		end
		acc = longint'($signed(cfg.b0)) * x + longint'($signed(cfg.b1)) * xp
			+ longint'($signed(cfg.a1)) * yp;
		acc = acc >>> COEF_FRAC;
		if (acc > SIG_MAX) begin
			return SIG_MAX;
		end
		if (acc < SIG_MIN) begin
			return SIG_MIN;
		end
		return acc;
	endfunction

	// both channels, wrapped difference, top dac bits
	// filter state advances on every accepted sample
	function automatic dac_word_t ref_word(adc_pair_t s);
		longint      x [2];
		longint      y [2];
		logic [63:0] diff;
		x[0] = longint'($signed(s.ch0)) * 256;
		x[1] = longint'($signed(s.ch1)) * 256;
		y[0] = iir_ref(i_filter_cfg.ch0, x[0], model_xp[0], model_yp[0]);
		y[1] = iir_ref(i_filter_cfg.ch1, x[1], model_xp[1], model_yp[1]);
		for (int i = 0; i < 2; i++) begin
			model_xp[i] = x[i];
			model_yp[i] = y[i];
		end
		diff = 64'(y[0] - y[1]);
		return dac_word_t'(diff[SIGNAL_WIDTH-1 -: DAC_WIDTH]);
	endfunction

	// narrow keeps every coefficient inside -1.0 .. +1.0
	function automatic iir_cfg_t rand_iir(input logic on, input logic narrow);
		iir_cfg_t c;
		c.on = on;
		if (narrow) begin
			c.a1 = coef_t'($urandom_range(65535));
			c.b0 = coef_t'(int'($urandom_range(131071)) - 65536);
			c.b1 = coef_t'(int'($urandom_range(131071)) - 65536);
		end else begin
			c.a1 = coef_t'($urandom);
			c.b0 = coef_t'($urandom);
			c.b1 = coef_t'($urandom);
		end
		return c;
	endfunction

	////////////////////////////////////////////////////////////////////////////
	// checks and bookkeeping

	task automatic check_value(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		check_count++;
		if (expected !== actual) begin
			err_count++;
			$display("FAILED %s: expected %h, actual %h", name, expected, actual);
		end
	endtask

	task automatic begin_test(input string name);
		cur_test       = name;
		test_err_start = err_count;
		test_count++;
	endtask

	task automatic end_test();
		if (err_count == test_err_start) begin
			$display("test %s: passed", cur_test);
		end else begin
			fail_tests++;
			$display("test %s: %0d errors", cur_test, err_count - test_err_start);
		end
	endtask

	////////////////////////////////////////////////////////////////////////////
	// stimulus

	// config only changes while reset holds the path idle
	task automatic reset_dut(input filter_cfg_t cfg);
		@(negedge clk1);
		i_rst        = 1'b1;
		i_adc_valid  = 1'b0;
		i_filter_cfg = cfg;
		repeat (5) @(negedge clk1);
		i_rst = 1'b0;
		exp_q.delete();
		for (int i = 0; i < 2; i++) begin
			model_xp[i] = 0;
			model_yp[i] = 0;
		end
	endtask

	// ready is stable from the posedge, so accept is known at the negedge
	task automatic drive_samples(input int unsigned count, input int unsigned valid_pct);
		int unsigned accepted;
		int unsigned idle;
		accepted = 0;
		idle     = 0;
		while (accepted < count && idle < STALL_LIMIT) begin
			@(negedge clk1);
			i_adc_valid = ($urandom_range(99) < valid_pct);
			i_adc       = adc_pair_t'($urandom);
			if (i_adc_valid && o_adc_ready) begin
				exp_q.push_back(ref_word(i_adc));
				accepted++;
				idle = 0;
			end else begin
				idle++;
			end
		end
		@(negedge clk1);
		i_adc_valid = 1'b0;
		if (accepted < count) begin
			err_count++;
			$display("%s: input stalled after %0d of %0d samples", cur_test, accepted, count);
		end
	endtask

	task automatic wait_drain();
		int unsigned waited;
		waited = 0;
		while ((exp_q.size() != 0 || o_dac_valid) && waited < DRAIN_LIMIT) begin
			@(negedge clk1);
			waited++;
		end
		if (exp_q.size() != 0) begin
			err_count++;
			$display("%s: %0d words never reached the dac output", cur_test, exp_q.size());
			exp_q.delete();
		end
	endtask

	////////////////////////////////////////////////////////////////////////////
	// dac side: ready pattern and compare

	initial begin
		forever begin
			@(negedge clk1);
			case (ready_mode)
				READY_HIGH: i_dac_ready = 1'b1;
				READY_LOW:  i_dac_ready = 1'b0;
				default:    i_dac_ready = ($urandom_range(99) < 50);
			endcase
			// transfer on the coming posedge
			if (o_dac_valid && i_dac_ready) begin
				if (exp_q.size() == 0) begin
					err_count++;
					$display("%s: dac word %h arrived with none expected", cur_test, o_dac);
				end else begin
					check_value(cur_test, 32'(exp_q.pop_front()), 32'(o_dac));
				end
			end
		end
	end

	// watchdog, sized from the sample count
	initial begin
		repeat (TOTAL_SAMPLES * CYCLE_ALLOW + 2000) @(posedge clk1);
		$display("watchdog expired during test %s", cur_test);
		$display("tests failed");
		$finish;
	end

	////////////////////////////////////////////////////////////////////////////
	// test sequence

	initial begin
		void'($urandom(SEED));
		i_rst        = 1'b1;
		i_adc        = '0;
		i_adc_valid  = 1'b0;
		i_filter_cfg = '0;
		i_dac_ready  = 1'b0;
		ready_mode   = READY_HIGH;
		err_count    = 0;
		check_count  = 0;
		test_count   = 0;
		fail_tests   = 0;
		cur_test     = "init";

		// zero filter state on the first word
		begin_test("reset");
		reset_dut({rand_iir(1'b1, 1'b1), rand_iir(1'b1, 1'b1)});
		check_value(cur_test, 32'(0), 32'(o_dac_valid));
		check_value(cur_test, 32'(1), 32'(o_adc_ready));
		drive_samples(4, 100);
		wait_drain();
		end_test();

		begin_test("bypass");
		reset_dut('0);
		drive_samples(N_BYPASS, 100);
		wait_drain();
		end_test();

		// full range coefficients, mostly at the rails
		begin_test("filter_sat");
		reset_dut({rand_iir(1'b1, 1'b0), rand_iir(1'b1, 1'b0)});
		drive_samples(N_FILTER, 100);
		wait_drain();
		end_test();

		begin_test("filter_lowpass");
		reset_dut({rand_iir(1'b1, 1'b1), rand_iir(1'b1, 1'b1)});
		drive_samples(N_FILTER, 100);
		wait_drain();
		end_test();

		// one word held at the dac, BUF_DEPTH in the buffer
		begin_test("backpressure");
		ready_mode = READY_LOW;
		reset_dut({rand_iir(1'b1, 1'b1), rand_iir(1'b0, 1'b1)});
		bp_accepted = 0;
		repeat (4 * BUF_DEPTH) begin
			@(negedge clk1);
			i_adc_valid = 1'b1;
			i_adc       = adc_pair_t'($urandom);
			if (o_adc_ready) begin
				exp_q.push_back(ref_word(i_adc));
				bp_accepted++;
			end
		end
		@(negedge clk1);
		check_value(cur_test, 32'(0), 32'(o_adc_ready));
		i_adc_valid = 1'b0;
		check_value(cur_test, 32'(BUF_DEPTH + 1), 32'(bp_accepted));
		ready_mode = READY_HIGH;
		wait_drain();
		end_test();

		begin_test("random_flow");
		ready_mode = READY_RANDOM;
		reset_dut({rand_iir(1'b1, 1'b1), rand_iir(1'b1, 1'b1)});
		drive_samples(N_RANDOM, 50);
		wait_drain();
		end_test();

		$display("summary: %0d tests, %0d failing, %0d checks, %0d errors",
			test_count, fail_tests, check_count, err_count);
		if (err_count == 0) begin
			$display("all tests passed");
		end else begin
			$display("tests failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: verilog/servo_top.sv
////////////////////////////////////////////////////////////////////////////
// servo signal path: filtered adc difference to the fast dac word
////////////////////////////////////////////////////////////////////////////

`default_nettype none

module servo_top
	import servo_sig_pkg::*;
	import servo_cfg_pkg::*;
#(
	parameter int BUF_DEPTH    = 8,
	parameter int CREDIT_WIDTH = 4
) (
	input  wire logic        i_clk1,
	input  wire logic        i_rst,
	input  wire adc_pair_t   i_adc,
	input  wire logic        i_adc_valid,
	output logic             o_adc_ready,
	input  wire filter_cfg_t i_filter_cfg,
	output dac_word_t        o_dac,
	output logic             o_dac_valid,
	input  wire logic        i_dac_ready
);

	// producer to buffer
	logic    push;
	signal_t push_data;
	logic    credit;

	// buffer to consumer
	logic    not_empty;
	signal_t head;
	logic    pop;

	////////////////////////////////////////////////////////////////////////////
	// filters and difference

	adc_filter_bank #(
		.BUF_DEPTH    (BUF_DEPTH),
		.CREDIT_WIDTH (CREDIT_WIDTH)
	) u_filter_bank (
		.i_clk1       (i_clk1),
		.i_rst        (i_rst),
		.i_adc        (i_adc),
		.i_adc_valid  (i_adc_valid),
		.o_adc_ready  (o_adc_ready),
		.i_filter_cfg (i_filter_cfg),
		.i_credit     (credit),
		.o_push       (push),
		.o_push_data  (push_data)
	);

	////////////////////////////////////////////////////////////////////////////
	// buffer

	sample_buffer #(
		.BUF_DEPTH (BUF_DEPTH)
	) u_buffer (
		.i_clk1      (i_clk1),
		.i_rst       (i_rst),
		.i_push      (push),
		.i_push_data (push_data),
		.i_pop       (pop),
		.o_not_empty (not_empty),
		.o_head      (head),
		.o_credit    (credit)
	);

	////////////////////////////////////////////////////////////////////////////
	// dac word

	dac_output_stage u_dac_stage (
		.i_clk1      (i_clk1),
		.i_rst       (i_rst),
		.i_not_empty (not_empty),
		.i_head      (head),
		.o_pop       (pop),
		.i_dac_ready (i_dac_ready),
		.o_dac_valid (o_dac_valid),
		.o_dac       (o_dac)
	);

endmodule

`default_nettype wire

// File: verilog/dac_output_stage.sv
////////////////////////////////////////////////////////////////////////////
// dac output stage: pops the buffer, keeps the msbs, holds under stall
////////////////////////////////////////////////////////////////////////////

`default_nettype none

module dac_output_stage
	import servo_sig_pkg::*;
(
	input  wire logic    i_clk1,
	input  wire logic    i_rst,
	input  wire logic    i_not_empty,
	input  wire signal_t i_head,
	output logic         o_pop,
	input  wire logic    i_dac_ready,
	output logic         o_dac_valid,
	output dac_word_t    o_dac
);

	logic slot_free;

	// word register empty or leaving this cycle
	assign slot_free = ~o_dac_valid | i_dac_ready;
	assign o_pop     = i_not_empty & slot_free;

	// valid flag
	always_ff @(posedge i_clk1) begin
		if (i_rst) begin
			o_dac_valid <= 1'b0;
		end else if (o_pop) begin
			o_dac_valid <= 1'b1;
		end else if (i_dac_ready) begin
			// transfer done, nothing new
			o_dac_valid <= 1'b0;
		end
	end

	// top dac bits of the difference
	// word stays put until the transfer
	always_ff @(posedge i_clk1) begin
		if (o_pop) begin
			o_dac <= i_head[SIGNAL_WIDTH-1 -: DAC_WIDTH];
		end
	end

endmodule

`default_nettype wire

// File: verilog/sample_buffer.sv
////////////////////////////////////////////////////////////////////////////
// sample buffer: circular fifo of differences, one credit back per pop
////////////////////////////////////////////////////////////////////////////

`default_nettype none

module sample_buffer
	import servo_sig_pkg::*;
#(
	parameter int BUF_DEPTH = 8
) (
	input  wire logic    i_clk1,
	input  wire logic    i_rst,
	input  wire logic    i_push,
	input  wire signal_t i_push_data,
	input  wire logic    i_pop,
	output logic         o_not_empty,
	output signal_t      o_head,
	output logic         o_credit
);

	localparam int PTR_WIDTH = (BUF_DEPTH > 1) ? $clog2(BUF_DEPTH) : 1;
	localparam int CNT_WIDTH = $clog2(BUF_DEPTH + 1);

	typedef logic [PTR_WIDTH-1:0] ptr_t;
	typedef logic [CNT_WIDTH-1:0] cnt_t;

	localparam ptr_t PTR_LAST = ptr_t'(BUF_DEPTH - 1);

	signal_t mem [BUF_DEPTH];
	ptr_t    wr_ptr;
	ptr_t    rd_ptr;
	cnt_t    count;
	logic    pop;

	assign o_not_empty = (count != '0);
	assign o_head      = mem[rd_ptr];
	// no pop from an empty buffer
	assign pop         = i_pop & o_not_empty;

	// storage
	// the producer holds a credit for every push, so no full check
	always_ff @(posedge i_clk1) begin
		if (i_push) begin
			mem[wr_ptr] <= i_push_data;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// pointers and occupancy

	always_ff @(posedge i_clk1) begin
		if (i_rst) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (i_push) begin
				wr_ptr <= (wr_ptr == PTR_LAST) ? '0 : wr_ptr + ptr_t'(1);
			end
			if (pop) begin
				rd_ptr <= (rd_ptr == PTR_LAST) ? '0 : rd_ptr + ptr_t'(1);
			end
			case ({i_push, pop})
				2'b10:   count <= count + cnt_t'(1);
				2'b01:   count <= count - cnt_t'(1);
				default: count <= count;
			endcase
		end
	end

	// credit one cycle after each pop
	always_ff @(posedge i_clk1) begin
		if (i_rst) begin
			o_credit <= 1'b0;
		end else begin
			o_credit <= pop;
		end
	end

endmodule

`default_nettype wire

// File: verilog/adc_filter_bank.sv
////////////////////////////////////////////////////////////////////////////
// adc filter bank: two iir channels, registered difference and credit
// flow control toward the sample buffer
////////////////////////////////////////////////////////////////////////////

`default_nettype none

module adc_filter_bank
	import servo_sig_pkg::*;
	import servo_cfg_pkg::*;
#(
	parameter int BUF_DEPTH    = 8,
	parameter int CREDIT_WIDTH = 4
) (
	input  wire logic        i_clk1,
	input  wire logic        i_rst,
	input  wire adc_pair_t   i_adc,
	input  wire logic        i_adc_valid,
	output logic             o_adc_ready,
	input  wire filter_cfg_t i_filter_cfg,
	input  wire logic        i_credit,
	output logic             o_push,
	output signal_t          o_push_data
);

	typedef logic [CREDIT_WIDTH-1:0] credit_t;

	// one credit per buffer slot
	localparam credit_t CREDIT_INIT = credit_t'(BUF_DEPTH);

	credit_t credit_cnt;
	logic    accept;
	logic    valid_d1;
	signal_t filt_ch0;
	signal_t filt_ch1;

	////////////////////////////////////////////////////////////////////////////
	// accept and credit counter

	// ready while a buffer slot is still unreserved
	assign o_adc_ready = (credit_cnt != '0);
	assign accept      = i_adc_valid & o_adc_ready;

	// credit reserved at acceptance
	// returned when the buffer hands the entry to the dac stage
	always_ff @(posedge i_clk1) begin
		if (i_rst) begin
			credit_cnt <= CREDIT_INIT;
		end else begin
			case ({accept, i_credit})
				2'b10:   credit_cnt <= credit_cnt - credit_t'(1);
				2'b01:   credit_cnt <= credit_cnt + credit_t'(1);
				default: credit_cnt <= credit_cnt;
			endcase
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// channel filters

	iir_first_order u_iir_ch0 (
		.i_clk1   (i_clk1),
		.i_rst    (i_rst),
		.i_cfg    (i_filter_cfg.ch0),
		.i_valid  (accept),
		.i_sample (i_adc.ch0),
		.o_signal (filt_ch0)
	);

	iir_first_order u_iir_ch1 (
		.i_clk1   (i_clk1),
		.i_rst    (i_rst),
		.i_cfg    (i_filter_cfg.ch1),
		.i_valid  (accept),
		.i_sample (i_adc.ch1),
		.o_signal (filt_ch1)
	);

	////////////////////////////////////////////////////////////////////////////
	// difference stage

	// valid follows the filter register
	always_ff @(posedge i_clk1) begin
		if (i_rst) begin
			valid_d1 <= 1'b0;
			o_push   <= 1'b0;
		end else begin
			valid_d1 <= accept;
			o_push   <= valid_d1;
		end
	end

	// ch0 - ch1, wraps at the signal width
	always_ff @(posedge i_clk1) begin
		if (valid_d1) begin
			o_push_data <= filt_ch0 - filt_ch1;
		end
	end

endmodule

`default_nettype wire

// File: verilog/iir_first_order.sv
////////////////////////////////////////////////////////////////////////////
// first-order iir low-pass on one adc channel, bypassed when cfg.on is low
////////////////////////////////////////////////////////////////////////////

`default_nettype none

module iir_first_order
	import servo_sig_pkg::*;
	import servo_cfg_pkg::*;
(
	input  wire logic     i_clk1,
	input  wire logic     i_rst,
	input  wire iir_cfg_t i_cfg,
	input  wire logic     i_valid,
	input  wire adc_raw_t i_sample,
	output signal_t       o_signal
);

	// product and accumulator widths
	localparam int PROD_WIDTH = COEF_WIDTH + SIGNAL_WIDTH;
	// three products summed, two guard bits
	localparam int ACC_WIDTH  = PROD_WIDTH + 2;

	signal_t                      x_in;
	signal_t                      x_prev;
	signal_t                      y_next;
	logic signed [PROD_WIDTH-1:0] prod_b0;
	logic signed [PROD_WIDTH-1:0] prod_b1;
	logic signed [PROD_WIDTH-1:0] prod_a1;
	logic signed [ACC_WIDTH-1:0]  acc;
	logic signed [ACC_WIDTH-1:0]  acc_shift;
	logic [ACC_WIDTH-SIGNAL_WIDTH:0] acc_hi;

	// raw sample moved up to the signal width
	assign x_in = {i_sample, {(SIGNAL_WIDTH-RAW_WIDTH){1'b0}}};

	always_comb begin
		prod_b0   = i_cfg.b0 * x_in;
		prod_b1   = i_cfg.b1 * x_prev;
		// feedback from the output register
		prod_a1   = i_cfg.a1 * o_signal;
		acc       = prod_b0 + prod_b1 + prod_a1;
		acc_shift = acc >>> COEF_FRAC;
		// sign bit of the result plus everything above it
		acc_hi    = acc_shift[ACC_WIDTH-1:SIGNAL_WIDTH-1];

		if (!i_cfg.on) begin
			// bypass
			y_next = x_in;
		end else if (&acc_hi || ~|acc_hi) begin
			// fits
			y_next = acc_shift[SIGNAL_WIDTH-1:0];
		end else if (acc_shift[ACC_WIDTH-1]) begin
			// clip at the negative rail
			y_next = {1'b1, {(SIGNAL_WIDTH-1){1'b0}}};
		end else begin
			// clip at the positive rail
			y_next = {1'b0, {(SIGNAL_WIDTH-1){1'b1}}};
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// filter state

	// state advances on every sample, on or off
	always_ff @(posedge i_clk1) begin
		if (i_rst) begin
			x_prev   <= '0;
			o_signal <= '0;
		end else if (i_valid) begin
			x_prev   <= x_in;
			o_signal <= y_next;
		end
	end

endmodule

`default_nettype wire

// File: verilog/servo_cfg_pkg.sv
////////////////////////////////////////////////////////////////////////////
// filter configuration: coefficient type and per-channel iir settings
////////////////////////////////////////////////////////////////////////////

`default_nettype none

package servo_cfg_pkg;

	////////////////////////////////////////////////////////////////////////////
	// coefficients

	// fixed point, 16 fractional bits
	localparam int COEF_FRAC  = 16;
	localparam int COEF_WIDTH = 20;

	// covers roughly -8.0 .. +8.0
	typedef logic signed [COEF_WIDTH-1:0] coef_t;

	////////////////////////////////////////////////////////////////////////////
	// configuration structs

	// one first-order section
	// y[n] = b0*x[n] + b1*x[n-1] + a1*y[n-1]
	typedef struct packed {
		logic  on;
		coef_t a1;
		coef_t b0;
		coef_t b1;
	} iir_cfg_t;

	// one filter per adc channel
	typedef struct packed {
		iir_cfg_t ch0;
		iir_cfg_t ch1;
	} filter_cfg_t;

endpackage

`default_nettype wire

// File: verilog/servo_sig_pkg.sv
////////////////////////////////////////////////////////////////////////////
// servo signal path types: raw adc samples, filtered signal, dac word
////////////////////////////////////////////////////////////////////////////

`default_nettype none

package servo_sig_pkg;

	////////////////////////////////////////////////////////////////////////////
	// widths

	// one ltc2195 channel
	localparam int RAW_WIDTH    = 16;
	// filtered value and channel difference
	localparam int SIGNAL_WIDTH = 24;
	// fast dac word, msbs of the signal
	localparam int DAC_WIDTH    = 16;

	////////////////////////////////////////////////////////////////////////////
	// types

	typedef logic signed [RAW_WIDTH-1:0]    adc_raw_t;
	typedef logic signed [SIGNAL_WIDTH-1:0] signal_t;
	typedef logic signed [DAC_WIDTH-1:0]    dac_word_t;

	// both adc channels, sampled together
	typedef struct packed {
		adc_raw_t ch0;
		adc_raw_t ch1;
	} adc_pair_t;

endpackage

`default_nettype wire
